// File: build.f
verilog/align_pkg.sv
verilog/addr_split.sv
verilog/write_merge.sv
verilog/read_track.sv
verilog/read_combine.sv
verilog/align_top.sv
sim/clk_gen.sv
sim/row_sram_model.sv
sim/align_props.sv
sim/align_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the align testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module align_tb -o align_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/align_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  echo "RESULT: FAIL"
  exit 1
fi

echo "RESULT: PASS"
exit 0

// File: sim/align_props.sv
`timescale 1ns/1ps

module align_props (
  input logic clk,
  input logic rst,
  input logic write,
  input logic read,
  input logic mem_write,
  input logic mem_read,
  input logic rd_fwrd
);

  import align_pkg::*;

  int unsigned since_rst;  // cycles since reset released

  always @(posedge clk) begin
    if (rst) begin
      since_rst <= 0;
    end else if (since_rst < 1000) begin
      since_rst <= since_rst + 1;
    end
  end

  wr_gate: assert property (@(posedge clk) mem_write |-> write)
    else $error("mem_write high without a write strobe");

  rd_pass: assert property (@(posedge clk) mem_read == read)
    else $error("mem_read differs from read");

  fwd_known: assert property (@(posedge clk)
    (!rst && since_rst >= SRAM_DELAY) |-> !$isunknown(rd_fwrd))
    else $error("rd_fwrd unknown after reset");

endmodule

bind align_top align_props props_i (
  .clk       (clk),
  .rst       (rst),
  .write     (write),
  .read      (read),
  .mem_write (mem_write),
  .mem_read  (mem_read),
  .rd_fwrd   (rd_fwrd)
);

// File: sim/align_tb.sv
`timescale 1ns/1ps

module align_tb;

  import align_pkg::*;

  localparam int RST_CYC = 5;
  localparam int CLK_NS = 40;
  localparam int N_PLAIN = 40;
  localparam int N_MIX = 48;
  localparam int N_FLIP = 2;
  localparam int TEST_CYC = (3 * N_PLAIN + 12) + 16 + 16 + (N_MIX + 32) + (8 * N_FLIP + 12);
  localparam int WD_NS = (RST_CYC + TEST_CYC + 50) * CLK_NS;

  typedef struct packed {
    logic [31:0]         due;
    logic [BIT_ADDR-1:0] addr;
    logic [WIDTH-1:0]    dout;
    logic                fwd;
    logic                serr;
    logic [BIT_PADR-1:0] padr;
  } exp_t;

  logic                clk;
  logic                rst;
  logic                write;
  logic                read;
  logic [BIT_ADDR-1:0] wr_adr;
  logic [BIT_ADDR-1:0] rd_adr;
  logic [WIDTH-1:0]    din;
  logic [WIDTH-1:0]    rd_dout;
  logic                rd_fwrd;
  logic                rd_serr;
  logic [BIT_PADR-1:0] rd_padr;
  logic                mem_write;
  logic                mem_read;
  logic [BIT_SROW-1:0] mem_wr_adr;
  logic [BIT_SROW-1:0] mem_rd_adr;
  row_u                mem_bw;
  row_u                mem_din;
  row_u                mem_rd_dout;

  logic [WIDTH-1:0]    ref_mem [NUM_ADDR];
  logic [WIDTH-1:0]    flip_msk [NUM_ADDR];  // bits flipped inside the sram
  logic                m_vld;  // mirror of the merge buffer
  int                  m_row;
  logic [NUM_WRDS-1:0] m_msk;
  exp_t                exp_q [$];
  exp_t                cur;
  logic [31:0]         neg_cnt;
  int                  seed = 83844;
  int                  err_cnt;
  int                  check_cnt;
  int                  fwd_seen_cnt;

  clk_gen clk_gen_i (.clk (clk));
  row_sram_model mem_i (.*);
  align_top dut_i (.*);

  function automatic int rand_addr();
    return int'({$random(seed)} % NUM_ADDR);
  endfunction

  function automatic int rand_slot();
    return int'({$random(seed)} % NUM_WRDS);
  endfunction

  function automatic logic [WIDTH-1:0] rand_data();
    return WIDTH'($random(seed));
  endfunction

  // drives one clock of stimulus and queues the expected read result
  task automatic do_cycle(input logic wr, input int wa, input logic [WIDTH-1:0] d,
                          input logic rd, input int ra);
    exp_t e;
    logic collide;
    logic hit;
    @(posedge clk);
    write <= wr;
    wr_adr <= BIT_ADDR'(wa);
    din <= d;
    read <= rd;
    rd_adr <= BIT_ADDR'(ra);
    if (rd) begin
      e.due = neg_cnt + 3;
      e.addr = BIT_ADDR'(ra);
      e.fwd = m_vld && (ra % NUM_SROW == m_row) && m_msk[ra / NUM_SROW];
      e.dout = e.fwd ? ref_mem[ra] : ref_mem[ra] ^ flip_msk[ra];
      e.serr = !e.fwd && (flip_msk[ra] != '0);
      e.padr = {BIT_WRDS'(ra / NUM_SROW), BIT_SROW'(ra % NUM_SROW)};
      exp_q.push_back(e);
    end
    collide = wr && rd && (wa % NUM_SROW == ra % NUM_SROW);
    hit = m_vld && (wa % NUM_SROW == m_row);
    if (collide || (wr && hit)) begin
      if (!hit) begin
        m_msk = '0;
      end
      m_msk[wa / NUM_SROW] = 1'b1;
      m_row = wa % NUM_SROW;
    end
    if (collide) begin
      m_vld = 1'b1;
    end
    if (wr) begin
      ref_mem[wa] = d;
      flip_msk[wa] = '0;
    end
  endtask

  task automatic wait_results();
    int guard;
    guard = 0;
    while (exp_q.size() != 0 && guard < 2 * SRAM_DELAY + 4) begin
      do_cycle(1'b0, 0, '0, 1'b0, 0);
      guard++;
    end
    assert (exp_q.size() == 0) else begin
      $display("read results still missing after %0d idle cycles at t=%0t", guard, $time);
      err_cnt++;
      exp_q.delete();
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
  endtask

  // read outputs are stable at the negedge
  always @(negedge clk) begin
    neg_cnt = neg_cnt + 1;
    if (exp_q.size() != 0 && exp_q[0].due == neg_cnt) begin
      cur = exp_q.pop_front();
      check_cnt++;
      if (rd_fwrd === 1'b1) begin
        fwd_seen_cnt++;
      end
      assert (rd_dout === cur.dout) else begin
        $display("FAILED t=%0t rd_dout expected=%h actual=%h addr=%0d",
                 $time, cur.dout, rd_dout, cur.addr);
        err_cnt++;
      end
      assert (rd_fwrd === cur.fwd) else begin
        $display("FAILED t=%0t rd_fwrd expected=%b actual=%b addr=%0d",
                 $time, cur.fwd, rd_fwrd, cur.addr);
        err_cnt++;
      end
      assert (rd_serr === cur.serr) else begin
        $display("FAILED t=%0t rd_serr expected=%b actual=%b addr=%0d",
                 $time, cur.serr, rd_serr, cur.addr);
        err_cnt++;
      end
      assert (rd_padr === cur.padr) else begin
        $display("FAILED t=%0t rd_padr expected=%h actual=%h addr=%0d",
                 $time, cur.padr, rd_padr, cur.addr);
        err_cnt++;
      end
    end
  end

  task automatic test_plain_rw();
    int e0;
    int a;
    int addrs [$];
    e0 = err_cnt;
    for (int i = 0; i < N_PLAIN; i++) begin
      // first and last address of every row span, then random ones
      a = (i < 8) ? (i / 2) * NUM_SROW + (i % 2) * (NUM_SROW - 1) : rand_addr();
      addrs.push_back(a);
      do_cycle(1'b1, a, rand_data(), 1'b0, 0);
      do_cycle(1'b0, 0, '0, 1'b1, a);
    end
    foreach (addrs[i]) begin
      do_cycle(1'b0, 0, '0, 1'b1, addrs[i]);  // back to back reads
    end
    wait_results();
    report_test(1, "plain write and read", e0);
  endtask

  task automatic test_same_row();
    int e0;
    int a;
    int b;
    e0 = err_cnt;
    a = rand_addr();
    b = ((a / NUM_SROW + 1) % NUM_WRDS) * NUM_SROW + a % NUM_SROW;
    do_cycle(1'b1, a, rand_data(), 1'b0, 0);
    do_cycle(1'b1, b, rand_data(), 1'b0, 0);
    do_cycle(1'b1, a, rand_data(), 1'b1, b);  // other slot, same row
    do_cycle(1'b0, 0, '0, 1'b1, a);
    do_cycle(1'b1, a, rand_data(), 1'b1, a);  // same address sees the old word
    do_cycle(1'b0, 0, '0, 1'b1, a);
    do_cycle(1'b0, 0, '0, 1'b1, b);
    wait_results();
    report_test(2, "same-row write and read", e0);
  endtask

  task automatic test_forward();
    int e0;
    int f0;
    int row;
    e0 = err_cnt;
    f0 = fwd_seen_cnt;
    row = (m_row + 13) % NUM_SROW;
    do_cycle(1'b1, row, rand_data(), 1'b1, 3 * NUM_SROW + row);
    do_cycle(1'b0, 0, '0, 1'b1, row);
    do_cycle(1'b1, row, rand_data(), 1'b0, 0);  // merges into the buffer
    do_cycle(1'b0, 0, '0, 1'b1, row);
    do_cycle(1'b0, 0, '0, 1'b1, 3 * NUM_SROW + row);
    do_cycle(1'b1, 3 * NUM_SROW + row, rand_data(), 1'b0, 0);
    do_cycle(1'b0, 0, '0, 1'b1, 3 * NUM_SROW + row);
    wait_results();
    assert (fwd_seen_cnt > f0) else begin
      $display("forwarding test saw no read result with rd_fwrd set");
      err_cnt++;
    end
    report_test(3, "forwarding", e0);
  endtask

  task automatic test_drain();
    int e0;
    int old_row;
    int row_x;
    int row_y;
    int wa;
    int ra;
    e0 = err_cnt;
    old_row = m_row;
    row_x = (old_row + 29) % NUM_SROW;
    row_y = (old_row + 30) % NUM_SROW;
    do_cycle(1'b1, NUM_SROW + row_x, rand_data(), 1'b1, 2 * NUM_SROW + row_x);
    do_cycle(1'b0, 0, '0, 1'b1, NUM_SROW + row_x);
    for (int s = 0; s < NUM_WRDS; s++) begin
      do_cycle(1'b0, 0, '0, 1'b1, s * NUM_SROW + old_row);
    end
    // random traffic over two rows keeps the buffer moving
    for (int i = 0; i < N_MIX; i++) begin
      wa = rand_slot() * NUM_SROW + ((($random(seed) & 1) != 0) ? row_x : row_y);
      ra = rand_slot() * NUM_SROW + ((($random(seed) & 1) != 0) ? row_x : row_y);
      do_cycle(($random(seed) & 1) != 0, wa, rand_data(), ($random(seed) & 1) != 0, ra);
    end
    for (int s = 0; s < NUM_WRDS; s++) begin
      do_cycle(1'b0, 0, '0, 1'b1, s * NUM_SROW + row_x);
      do_cycle(1'b0, 0, '0, 1'b1, s * NUM_SROW + row_y);
    end
    wait_results();
    report_test(4, "buffer drain", e0);
  endtask

  task automatic test_parity();
    int e0;
    int row;
    int p;
    int bit_i;
    e0 = err_cnt;
    row = (m_row + 31) % NUM_SROW;  // away from the buffered row
    for (int i = 0; i < N_FLIP; i++) begin
      p = rand_slot() * NUM_SROW + row;
      bit_i = int'({$random(seed)} % WIDTH);
      do_cycle(1'b1, p, rand_data(), 1'b0, 0);
      do_cycle(1'b0, 0, '0, 1'b0, 0);
      @(negedge clk);
      mem_i.flip_bit(row, (p / NUM_SROW) * MEM_WDTH + bit_i);
      flip_msk[p] = WIDTH'(1) << bit_i;
      do_cycle(1'b0, 0, '0, 1'b1, p);
      do_cycle(1'b1, p, rand_data(), 1'b0, 0);  // rewrite restores parity
      do_cycle(1'b0, 0, '0, 1'b1, p);
    end
    wait_results();
    report_test(5, "parity error", e0);
  endtask

  initial begin
    #(WD_NS);
    $display("watchdog expired at t=%0t, the tests did not finish", $time);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst = 1'b1;
    write = 1'b0;
    read = 1'b0;
    wr_adr = '0;
    rd_adr = '0;
    din = '0;
    m_vld = 1'b0;
    m_row = 0;
    m_msk = '0;
    neg_cnt = '0;
    err_cnt = 0;
    check_cnt = 0;
    fwd_seen_cnt = 0;
    for (int a = 0; a < NUM_ADDR; a++) begin
      ref_mem[a] = '0;
      flip_msk[a] = '0;
    end
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    test_plain_rw();
    test_same_row();
    test_forward();
    test_drain();
    test_parity();
    $display("summary: 5 tests, %0d reads checked, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;  // 40 ns period
    end
  end

endmodule

// File: sim/row_sram_model.sv
`timescale 1ns/1ps

module row_sram_model (
  input  logic                           clk,
  input  logic                           mem_write,
  input  logic [align_pkg::BIT_SROW-1:0] mem_wr_adr,
  input  align_pkg::row_u                mem_bw,
  input  align_pkg::row_u                mem_din,
  input  logic                           mem_read,
  input  logic [align_pkg::BIT_SROW-1:0] mem_rd_adr,
  output align_pkg::row_u                mem_rd_dout
);

  import align_pkg::*;

  row_u mem [NUM_SROW];
  row_u rd_pipe [SRAM_DELAY];

  initial begin
    for (int r = 0; r < NUM_SROW; r++) begin
      mem[r] = '0;
    end
    for (int i = 0; i < SRAM_DELAY; i++) begin
      rd_pipe[i] = '0;
    end
  end

  always @(posedge clk) begin
    if (mem_write) begin
      mem[mem_wr_adr].flat <= (mem[mem_wr_adr].flat & ~mem_bw.flat)
                              | (mem_din.flat & mem_bw.flat);
    end
    if (mem_read) begin
      rd_pipe[0] <= mem[mem_rd_adr];  // old data on a same-edge write
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign mem_rd_dout = rd_pipe[SRAM_DELAY-1];

  // flips one stored bit and leaves its parity bit alone
  task automatic flip_bit(input int row, input int bit_idx);
    mem[row].flat[bit_idx] = ~mem[row].flat[bit_idx];
  endtask

endmodule

// File: verilog/addr_split.sv
`timescale 1ns/1ps

module addr_split (
  input  logic [align_pkg::BIT_ADDR-1:0] addr,
  output logic [align_pkg::BIT_WRDS-1:0] slot,
  output logic [align_pkg::BIT_SROW-1:0] row
);

  import align_pkg::*;

  logic [BIT_ADDR-1:0] rem;

  // slot = addr / NUM_SROW, row = addr % NUM_SROW
  // addr < NUM_WRDS*NUM_SROW, so NUM_WRDS-1 subtract steps are enough
  always_comb begin
    rem = addr;
    slot = '0;
    for (int i = 1; i < NUM_WRDS; i++) begin
      if (rem >= BIT_ADDR'(NUM_SROW)) begin
        rem = rem - BIT_ADDR'(NUM_SROW);
        slot = slot + 1'b1;
      end
    end
    row = rem[BIT_SROW-1:0];
  end

endmodule

// File: verilog/align_pkg.sv
package align_pkg;

  localparam int WIDTH = 16;
  localparam int MEM_WDTH = WIDTH + 1;  // data plus even parity

  localparam int NUM_ADDR = 240;
  localparam int BIT_ADDR = 8;

  localparam int NUM_SROW = 60;  // not a power of two
  localparam int BIT_SROW = 6;

  localparam int NUM_WRDS = 4;
  localparam int BIT_WRDS = 2;

  localparam int ROW_BITS = NUM_WRDS * MEM_WDTH;
  localparam int BIT_PADR = BIT_WRDS + BIT_SROW;  // {slot, row}

  localparam int SRAM_DELAY = 2;

  // one sram row, seen flat for bit masks or per word slot
  typedef union packed {
    logic [ROW_BITS-1:0] flat;
    logic [NUM_WRDS-1:0][MEM_WDTH-1:0] word;
  } row_u;

endpackage

// File: verilog/align_top.sv
`timescale 1ns/1ps

module align_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          write,
  input  logic [align_pkg::BIT_ADDR-1:0] wr_adr,
  input  logic [align_pkg::WIDTH-1:0]    din,
  input  logic                          read,
  input  logic [align_pkg::BIT_ADDR-1:0] rd_adr,
  output logic [align_pkg::WIDTH-1:0]    rd_dout,
  output logic                          rd_fwrd,
  output logic                          rd_serr,
  output logic [align_pkg::BIT_PADR-1:0] rd_padr,
  output logic                          mem_write,
  output logic [align_pkg::BIT_SROW-1:0] mem_wr_adr,
  output align_pkg::row_u               mem_bw,
  output align_pkg::row_u               mem_din,
  output logic                          mem_read,
  output logic [align_pkg::BIT_SROW-1:0] mem_rd_adr,
  input  align_pkg::row_u               mem_rd_dout
);

  import align_pkg::*;

  logic [BIT_WRDS-1:0] wr_slot;
  logic [BIT_SROW-1:0] wr_row;
  logic [BIT_WRDS-1:0] rd_slot;
  logic [BIT_SROW-1:0] rd_row;

  logic                buf_vld;
  logic [BIT_SROW-1:0] buf_row;
  logic [NUM_WRDS-1:0] buf_msk;
  row_u                buf_dat;

  logic [BIT_WRDS-1:0] trk_slot;
  logic [BIT_SROW-1:0] trk_row;
  logic                trk_fwd;
  logic [MEM_WDTH-1:0] trk_dat;

  addr_split wr_split_i (
    .addr (wr_adr),
    .slot (wr_slot),
    .row  (wr_row)
  );

  addr_split rd_split_i (
    .addr (rd_adr),
    .slot (rd_slot),
    .row  (rd_row)
  );

  write_merge write_merge_i (
    .clk        (clk),
    .rst        (rst),
    .write      (write),
    .wr_slot    (wr_slot),
    .wr_row     (wr_row),
    .din        (din),
    .read       (read),
    .rd_row     (rd_row),
    .mem_write  (mem_write),
    .mem_wr_adr (mem_wr_adr),
    .mem_bw     (mem_bw),
    .mem_din    (mem_din),
    .buf_vld    (buf_vld),
    .buf_row    (buf_row),
    .buf_msk    (buf_msk),
    .buf_dat    (buf_dat)
  );

  read_track read_track_i (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .rd_slot  (rd_slot),
    .rd_row   (rd_row),
    .buf_vld  (buf_vld),
    .buf_row  (buf_row),
    .buf_msk  (buf_msk),
    .buf_dat  (buf_dat),
    .trk_slot (trk_slot),
    .trk_row  (trk_row),
    .trk_fwd  (trk_fwd),
    .trk_dat  (trk_dat)
  );

  read_combine read_combine_i (
    .trk_slot    (trk_slot),
    .trk_row     (trk_row),
    .trk_fwd     (trk_fwd),
    .trk_dat     (trk_dat),
    .mem_rd_dout (mem_rd_dout),
    .rd_dout     (rd_dout),
    .rd_fwrd     (rd_fwrd),
    .rd_serr     (rd_serr),
    .rd_padr     (rd_padr)
  );

  assign mem_read = read;  // every read goes to the sram
  assign mem_rd_adr = rd_row;

endmodule

// File: verilog/read_combine.sv
`timescale 1ns/1ps

module read_combine (
  input  logic [align_pkg::BIT_WRDS-1:0] trk_slot,
  input  logic [align_pkg::BIT_SROW-1:0] trk_row,
  input  logic                          trk_fwd,
  input  logic [align_pkg::MEM_WDTH-1:0] trk_dat,
  input  align_pkg::row_u               mem_rd_dout,
  output logic [align_pkg::WIDTH-1:0]    rd_dout,
  output logic                          rd_fwrd,
  output logic                          rd_serr,
  output logic [align_pkg::BIT_PADR-1:0] rd_padr
);

  import align_pkg::*;

  logic [MEM_WDTH-1:0] sram_word;
  logic [MEM_WDTH-1:0] sel_word;

  assign sram_word = mem_rd_dout.word[trk_slot];
  assign sel_word = trk_fwd ? trk_dat : sram_word;

  assign rd_dout = sel_word[WIDTH-1:0];  // parity bit dropped
  assign rd_fwrd = trk_fwd;
  assign rd_serr = !trk_fwd && (^sram_word);  // odd count means a flipped bit
  assign rd_padr = {trk_slot, trk_row};

endmodule

// File: verilog/read_track.sv
`timescale 1ns/1ps

module read_track (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          read,
  input  logic [align_pkg::BIT_WRDS-1:0] rd_slot,
  input  logic [align_pkg::BIT_SROW-1:0] rd_row,
  input  logic                          buf_vld,
  input  logic [align_pkg::BIT_SROW-1:0] buf_row,
  input  logic [align_pkg::NUM_WRDS-1:0] buf_msk,
  input  align_pkg::row_u               buf_dat,
  output logic [align_pkg::BIT_WRDS-1:0] trk_slot,
  output logic [align_pkg::BIT_SROW-1:0] trk_row,
  output logic                          trk_fwd,
  output logic [align_pkg::MEM_WDTH-1:0] trk_dat
);

  import align_pkg::*;

  logic                fwd_now;
  logic [BIT_WRDS-1:0] slot_q [SRAM_DELAY];
  logic [BIT_SROW-1:0] row_q  [SRAM_DELAY];
  logic                fwd_q  [SRAM_DELAY];
  logic [MEM_WDTH-1:0] dat_q  [SRAM_DELAY];

  // buffer state before the edge decides forwarding
  assign fwd_now = read && buf_vld && (rd_row == buf_row) && buf_msk[rd_slot];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SRAM_DELAY; i++) begin
        fwd_q[i] <= 1'b0;
      end
    end else begin
      fwd_q[0] <= fwd_now;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        fwd_q[i] <= fwd_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    slot_q[0] <= rd_slot;
    row_q[0] <= rd_row;
    dat_q[0] <= buf_dat.word[rd_slot];  // only meaningful when forwarded
    for (int i = 1; i < SRAM_DELAY; i++) begin
      slot_q[i] <= slot_q[i-1];
      row_q[i] <= row_q[i-1];
      dat_q[i] <= dat_q[i-1];
    end
  end

  assign trk_slot = slot_q[SRAM_DELAY-1];
  assign trk_row = row_q[SRAM_DELAY-1];
  assign trk_fwd = fwd_q[SRAM_DELAY-1];
  assign trk_dat = dat_q[SRAM_DELAY-1];

endmodule

// File: verilog/write_merge.sv
`timescale 1ns/1ps

module write_merge (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          write,
  input  logic [align_pkg::BIT_WRDS-1:0] wr_slot,
  input  logic [align_pkg::BIT_SROW-1:0] wr_row,
  input  logic [align_pkg::WIDTH-1:0]    din,
  input  logic                          read,
  input  logic [align_pkg::BIT_SROW-1:0] rd_row,
  output logic                          mem_write,
  output logic [align_pkg::BIT_SROW-1:0] mem_wr_adr,
  output align_pkg::row_u               mem_bw,
  output align_pkg::row_u               mem_din,
  output logic                          buf_vld,
  output logic [align_pkg::BIT_SROW-1:0] buf_row,
  output logic [align_pkg::NUM_WRDS-1:0] buf_msk,
  output align_pkg::row_u               buf_dat
);

  import align_pkg::*;

  logic [MEM_WDTH-1:0] din_par;
  logic [NUM_WRDS-1:0] wr_msk;
  row_u                wr_word;
  row_u                wr_bits;
  row_u                drain_bits;
  logic                collide;
  logic                buf_hit;

  assign din_par = {^din, din};  // even parity over the stored word

  // place the new word at its slot
  always_comb begin
    wr_msk = '0;
    wr_word = '0;
    wr_bits = '0;
    wr_msk[wr_slot] = 1'b1;
    wr_word.word[wr_slot] = din_par;
    wr_bits.word[wr_slot] = '1;
  end

  // slot mask of the buffer expanded to bits
  always_comb begin
    drain_bits = '0;
    for (int i = 0; i < NUM_WRDS; i++) begin
      drain_bits.word[i] = {MEM_WDTH{buf_msk[i]}};
    end
  end

  assign collide = write && read && (wr_row == rd_row);
  assign buf_hit = buf_vld && (wr_row == buf_row);

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_vld <= 1'b0;
    end else if (collide) begin
      buf_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (collide || (write && buf_hit)) begin
      buf_row <= wr_row;
      if (buf_hit) begin  // merge into the held row
        buf_msk <= buf_msk | wr_msk;
        buf_dat.flat <= (buf_dat.flat & ~wr_bits.flat) | wr_word.flat;
      end else begin  // old row drains this cycle
        buf_msk <= wr_msk;
        buf_dat <= wr_word;
      end
    end
  end

  // colliding write drains the buffer unless it is empty or on the read row
  assign mem_write = write && !(collide && (!buf_vld || (buf_row == rd_row)));
  assign mem_wr_adr = collide ? buf_row : wr_row;
  assign mem_bw = collide ? drain_bits : wr_bits;
  assign mem_din = collide ? buf_dat : wr_word;

endmodule
